/* compile.f */
hdl/board_addr_pkg.sv
hdl/axis_pkg.sv
hdl/reg_bus_if.sv
hdl/board_regs.sv
hdl/dac_cmd_regs.sv
hdl/safety_check.sv
hdl/reg_read_mux.sv
hdl/board_top.sv
sim/tb_board_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the board register testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top \
    -f compile.f -o tb_board_top > sim.log 2>&1 \
    && ./obj_dir/tb_board_top >> sim.log 2>&1 \
    || echo "build or run returned an error status" >> sim.log

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

/* sim/tb_board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;
    import board_addr_pkg::*;
    import axis_pkg::*;

    logic       sysclk;
    logic       rst_n;
    logic       reg_wen;
    reg_addr_t  reg_waddr;
    reg_addr_t  reg_raddr;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;
    logic [3:0] board_id;
    cur_arr_t   cur_fb;
    cur_arr_t   cur_cmd;
    axis_mask_t amp_disable;
    logic       pwr_enable;
    logic [3:0] dout;

    // expected register contents
    cur_t       model_cmd [NUM_AXES];   // [0] is chan 1
    logic [3:0] model_dout;
    logic       model_pwr;
    axis_mask_t model_amp;
    logic       mon_on;                 // compare process armed after reset
    integer     seed;

    board_top dut (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_raddr   (reg_raddr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .board_id    (board_id),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .dout        (dout)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // --------------------------------------------------
    // reference model and checks
    function automatic logic expect_trip(input cur_t fb, input cur_t cmd);
        logic [17:0] fb_mag;
        logic [17:0] cmd_mag;
        fb_mag  = (fb >= CUR_MID) ? 18'(fb - CUR_MID) : 18'(CUR_MID - fb);
        cmd_mag = (cmd >= CUR_MID) ? 18'(cmd - CUR_MID) : 18'(CUR_MID - cmd);
        return fb_mag > ((cmd_mag << 1) + 18'(SAFETY_MARGIN));   // 2x cmd + margin
    endfunction

    // {space, unused, chan, offset}
    function automatic reg_addr_t mk_addr(input logic [3:0] space, input logic [3:0] chan,
                                          input logic [3:0] off);
        return {space, 4'h0, chan, off};
    endfunction

    function automatic reg_data_t status_word(input logic [3:0] id, input logic pwr,
                                              input logic [3:0] amp, input logic [3:0] dio);
        reg_data_t w;
        w         = '0;
        w[27:24]  = id;
        w[19]     = pwr;
        w[11:8]   = amp;
        w[3:0]    = dio;
        return w;
    endfunction

    task automatic stop_on_failure;
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    // stay 1 ns past the rising edge
    task automatic next_cycle;
        @(posedge sysclk);
        #1;
    endtask

    task automatic wr(input reg_addr_t addr, input reg_data_t data);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        next_cycle();       // register loads at this edge
        reg_wen   = 1'b0;
    endtask

    // one cycle latency
    task automatic rd_check(input string name, input reg_addr_t addr, input reg_data_t exp);
        reg_raddr = addr;
        next_cycle();
        check_val(name, reg_rdata, exp);
    endtask

    task automatic wait_trip(input int ax, output int cycles);
        cycles = 0;
        while (amp_disable[ax] !== 1'b1) begin
            if (cycles == 50) begin
                $display("timeout: amp_disable[%0d] did not set within 50 cycles", ax);
                stop_on_failure();
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    // over-current on one axis for hold cycles, then back to zero amps
    task automatic over_current(input int ax, input cur_t level, input int hold);
        int waited;
        waited     = 0;
        cur_fb[ax] = level;
        if (expect_trip(level, model_cmd[ax]) && hold >= SAFETY_COUNT) begin
            wait_trip(ax, waited);
            // one edge to sample, then SAFETY_COUNT counting edges
            check_val($sformatf("amp_disable[%0d] trip cycles", ax), 32'(waited),
                      32'(SAFETY_COUNT + 1));
            model_amp[ax] = 1'b1;
        end
        while (waited < hold) begin
            next_cycle();
            waited++;
        end
        cur_fb[ax] = CUR_MID;
        repeat (12) begin   // latch holds and a short run never trips
            next_cycle();
            check_val("amp_disable", 32'(amp_disable), 32'(model_amp));
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge sysclk) begin
        if (mon_on) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                check_val($sformatf("cur_cmd[%0d]", i), 32'(cur_cmd[i]), 32'(model_cmd[i]));
            end
            check_val("dout", 32'(dout), 32'(model_dout));
            check_val("pwr_enable", 32'(pwr_enable), 32'(model_pwr));
        end
    end

    // --------------------------------------------------
    // stimulus
    initial begin
        reg_data_t data;
        cur_t      fb;
        int        ax;
        int        ax2;
        seed      = 32'h02b7e913;
        mon_on    = 1'b0;
        rst_n     = 1'b0;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_raddr = '0;
        reg_wdata = '0;
        board_id  = 4'hb;
        for (int i = 0; i < NUM_AXES; i++) begin
            cur_fb[i]    = CUR_MID;
            model_cmd[i] = CUR_MID;
        end
        model_dout = 4'h0;
        model_pwr  = 1'b0;
        model_amp  = '0;

        repeat (3) @(posedge sysclk);
        #1;
        rst_n = 1'b1;

        // reset values
        check_val("reg_rdata", reg_rdata, 32'h0);
        check_val("dout", 32'(dout), 32'h0);
        check_val("pwr_enable", 32'(pwr_enable), 32'h0);
        check_val("amp_disable", 32'(amp_disable), 32'h0);
        for (int i = 0; i < NUM_AXES; i++) begin
            check_val($sformatf("cur_cmd[%0d]", i), 32'(cur_cmd[i]), 32'(CUR_MID));
        end
        mon_on = 1'b1;

        // random commands with cmd and fb read-back
        for (int n = 0; n < 24; n++) begin
            ax   = int'($unsigned($random(seed)) % NUM_AXES);
            data = $random(seed);
            wr(mk_addr(ADDR_MAIN, 4'(ax + 1), OFF_DAC_CTRL), data);
            model_cmd[ax] = data[15:0];   // upper half dropped
            for (int i = 0; i < NUM_AXES; i++) begin
                fb = cur_t'($random(seed));
                if (expect_trip(fb, model_cmd[i])) begin
                    fb = model_cmd[i];    // keep clear of a trip
                end
                cur_fb[i] = fb;
            end
            rd_check("reg_rdata cmd", mk_addr(ADDR_MAIN, 4'(ax + 1), OFF_DAC_CTRL),
                     32'(model_cmd[ax]));
            ax2 = int'($unsigned($random(seed)) % NUM_AXES);
            rd_check("reg_rdata fb", mk_addr(ADDR_MAIN, 4'(ax2 + 1), OFF_ADC_DATA),
                     32'(cur_fb[ax2]));
        end
        check_val("amp_disable", 32'(amp_disable), 32'(model_amp));

        // ignored writes to another space and to chan 0
        wr(mk_addr(4'h1, 4'h1, OFF_DAC_CTRL), 32'h0000_1234);
        wr(mk_addr(ADDR_MAIN, 4'h0, OFF_DAC_CTRL), 32'h0000_5678);

        // --------------------------------------------------
        // channel 0 registers
        data = $random(seed);
        wr(mk_addr(ADDR_MAIN, 4'h0, REG_DIGIO), data);
        model_dout = data[3:0];
        rd_check("reg_rdata digio", mk_addr(ADDR_MAIN, 4'h0, REG_DIGIO), 32'(model_dout));
        wr(mk_addr(ADDR_MAIN, 4'h0, REG_STATUS), 32'h0008_0000);
        model_pwr = 1'b1;
        rd_check("reg_rdata status", mk_addr(ADDR_MAIN, 4'h0, REG_STATUS),
                 status_word(board_id, model_pwr, model_amp, model_dout));
        wr(mk_addr(ADDR_MAIN, 4'h0, REG_STATUS), 32'h0000_0000);
        model_pwr = 1'b0;
        rd_check("reg_rdata status", mk_addr(ADDR_MAIN, 4'h0, REG_STATUS),
                 status_word(board_id, model_pwr, model_amp, model_dout));
        rd_check("reg_rdata space 1", mk_addr(4'h1, 4'h1, OFF_DAC_CTRL), 32'h0);
        rd_check("reg_rdata space 3", mk_addr(4'h3, 4'h0, REG_STATUS), 32'h0);
        rd_check("reg_rdata chan0 off 5", mk_addr(ADDR_MAIN, 4'h0, 4'h5), 32'h0);
        rd_check("reg_rdata chan1 off 7", mk_addr(ADDR_MAIN, 4'h1, 4'h7), 32'h0);
        rd_check("reg_rdata chan 6", mk_addr(ADDR_MAIN, 4'h6, OFF_ADC_DATA), 32'h0);

        // --------------------------------------------------
        // over-current trips with zero command on every axis
        for (int i = 0; i < NUM_AXES; i++) begin
            wr(mk_addr(ADDR_MAIN, 4'(i + 1), OFF_DAC_CTRL), 32'(CUR_MID));
            model_cmd[i] = CUR_MID;
            cur_fb[i]    = CUR_MID;
        end
        over_current(2, CUR_MID + 16'h1000, 3);    // too short
        over_current(2, CUR_MID - 16'h1000, 20);   // negative current trips
        over_current(0, CUR_MID + 16'h2000, 20);
        rd_check("reg_rdata status", mk_addr(ADDR_MAIN, 4'h0, REG_STATUS),
                 status_word(board_id, model_pwr, model_amp, model_dout));

        // amp enable for axis 2 only with pwr bit low
        wr(mk_addr(ADDR_MAIN, 4'h0, REG_STATUS), 32'(1) << (STAT_AMP_LSB + 2));
        model_pwr = 1'b0;
        next_cycle();
        model_amp[2] = 1'b0;
        check_val("amp_disable", 32'(amp_disable), 32'(model_amp));
        rd_check("reg_rdata status", mk_addr(ADDR_MAIN, 4'h0, REG_STATUS),
                 status_word(board_id, model_pwr, model_amp, model_dout));

        // second tripped axis for the power enable clear
        over_current(3, CUR_MID + 16'h1000, 20);

        // power enable clears every axis
        wr(mk_addr(ADDR_MAIN, 4'h0, REG_STATUS), 32'(1) << STAT_PWR_BIT);
        model_pwr = 1'b1;
        next_cycle();
        model_amp = '0;
        check_val("amp_disable", 32'(amp_disable), 32'(model_amp));
        rd_check("reg_rdata status", mk_addr(ADDR_MAIN, 4'h0, REG_STATUS),
                 status_word(board_id, model_pwr, model_amp, model_dout));

        repeat (2) next_cycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  wire logic                      sysclk,
    input  wire logic                      rst_n,
    input  wire logic                      reg_wen,
    input  wire board_addr_pkg::reg_addr_t reg_waddr,
    input  wire board_addr_pkg::reg_addr_t reg_raddr,
    input  wire board_addr_pkg::reg_data_t reg_wdata,
    output wire board_addr_pkg::reg_data_t reg_rdata,
    input  wire logic [3:0]                board_id,    // rotary switch
    input  wire axis_pkg::cur_arr_t        cur_fb,      // measured currents
    output wire axis_pkg::cur_arr_t        cur_cmd,     // to current loop
    output wire axis_pkg::axis_mask_t      amp_disable,
    output wire logic                      pwr_enable,
    output wire logic [3:0]                dout
);
    import board_addr_pkg::*;
    import axis_pkg::*;

    reg_bus_if  bus ();
    axis_mask_t clear_disable;   // pwr or amp enable pulse
    reg_data_t  status_rdata;
    reg_data_t  digio_rdata;

    // host side of the bus
    assign bus.wen   = reg_wen;
    assign bus.waddr = reg_waddr;
    assign bus.wdata = reg_wdata;
    assign bus.raddr = reg_raddr;

    // ------------------------------------------------
    // channel 0 board registers
    board_regs u_chan0 (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .bus           (bus),
        .board_id      (board_id),
        .amp_disable   (amp_disable),
        .pwr_enable    (pwr_enable),
        .dout          (dout),
        .clear_disable (clear_disable),
        .status_rdata  (status_rdata),
        .digio_rdata   (digio_rdata)
    );

    // axis current commands, chan 1..4
    dac_cmd_regs u_dac (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .bus     (bus),
        .cur_cmd (cur_cmd)
    );

    reg_read_mux u_rd_mux (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .raddr        (bus.raddr),
        .status_rdata (status_rdata),
        .digio_rdata  (digio_rdata),
        .cmd_rdata    (cur_cmd),       // command read-back
        .cur_fb       (cur_fb),
        .rdata        (reg_rdata)
    );

    // ------------------------------------------------
    // per-axis over-current check
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_safe
        safety_check u_safe (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .cur_in        (cur_fb[i]),
            .dac_in        (cur_cmd[i]),
            .clear_disable (clear_disable[i]),
            .amp_disable   (amp_disable[i])
        );
    end

endmodule

`default_nettype wire

/* hdl/reg_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_read_mux (
    input  wire logic                      sysclk,
    input  wire logic                      rst_n,
    input  wire board_addr_pkg::reg_addr_t raddr,
    input  wire board_addr_pkg::reg_data_t status_rdata,
    input  wire board_addr_pkg::reg_data_t digio_rdata,
    input  wire axis_pkg::cur_arr_t        cmd_rdata,
    input  wire axis_pkg::cur_arr_t        cur_fb,
    output board_addr_pkg::reg_data_t      rdata
);
    import board_addr_pkg::*;
    import axis_pkg::*;

    chan_t                 chan;
    off_t                  off;
    logic [AXIS_IDX_W-1:0] axis;      // chan 1..4 -> 0..3
    reg_data_t             rdata_d;

    assign chan = addr_chan(raddr);
    assign off  = addr_off(raddr);
    assign axis = AXIS_IDX_W'(chan - 1'b1);

    // ------------------------------------------------
    // decode, anything unmapped reads 0
    always_comb begin
        rdata_d = '0;
        if (addr_space(raddr) == ADDR_MAIN) begin
            if (chan == '0) begin
                case (off)
                    REG_STATUS: rdata_d = status_rdata;
                    REG_DIGIO:  rdata_d = digio_rdata;
                    default:    rdata_d = '0;
                endcase
            end else if (chan < NUM_CHAN) begin
                case (off)
                    OFF_ADC_DATA: rdata_d = reg_data_t'(cur_fb[axis]);
                    OFF_DAC_CTRL: rdata_d = reg_data_t'(cmd_rdata[axis]);
                    default:      rdata_d = '0;
                endcase
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rdata_d;
        end
    end

    a_rdata_known : assert property (@(posedge sysclk) disable iff (!rst_n)
        !$isunknown(rdata))
        else $error("read data unknown");

endmodule

`default_nettype wire

/* hdl/safety_check.sv */
`timescale 1ns/1ps
`default_nettype none

module safety_check (
    input  wire logic           sysclk,
    input  wire logic           rst_n,
    input  wire axis_pkg::cur_t cur_in,    // measured current
    input  wire axis_pkg::cur_t dac_in,    // commanded current
    input  wire logic           clear_disable,
    output logic                amp_disable
);
    import axis_pkg::*;

    cur_t                    cur_q;
    cur_t                    dac_q;
    cur_t                    cur_mag;
    cur_t                    dac_mag;
    logic [CHK_W-1:0]        limit;
    logic                    over_cur;
    logic [SAFETY_CNT_W-1:0] over_cnt;   // saturates at SAFETY_COUNT

    // sample both inputs
    always_ff @(posedge sysclk) begin
        cur_q <= cur_in;
        dac_q <= dac_in;
    end

    // magnitudes about midscale
    assign cur_mag = (cur_q >= CUR_MID) ? (cur_q - CUR_MID) : (CUR_MID - cur_q);
    assign dac_mag = (dac_q >= CUR_MID) ? (dac_q - CUR_MID) : (CUR_MID - dac_q);

    assign limit    = CHK_W'({dac_mag, 1'b0}) + CHK_W'(SAFETY_MARGIN);   // 2x cmd + margin
    assign over_cur = CHK_W'(cur_mag) > limit;

    // ------------------------------------------------
    // consecutive count and latch
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin   // host clear wins
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (over_cur) begin
            if (over_cnt != SAFETY_CNT_W'(SAFETY_COUNT)) begin
                over_cnt <= over_cnt + 1'b1;
            end
            if (over_cnt == SAFETY_CNT_W'(SAFETY_COUNT - 1)) begin
                amp_disable <= 1'b1;   // this edge completes the run
            end
        end else begin
            over_cnt <= '0;   // run broken, latch holds
        end
    end

    a_trip_count : assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(amp_disable) |-> (over_cnt == SAFETY_CNT_W'(SAFETY_COUNT)))
        else $error("amp_disable set before SAFETY_COUNT over-current cycles");

endmodule

`default_nettype wire

/* hdl/dac_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_cmd_regs (
    input  wire logic          sysclk,
    input  wire logic          rst_n,
    reg_bus_if.target          bus,
    output axis_pkg::cur_arr_t cur_cmd   // [0] is chan 1
);
    import board_addr_pkg::*;
    import axis_pkg::*;

    axis_mask_t axis_sel;   // write select per axis

    // axis i lives at chan i+1, offset OFF_DAC_CTRL
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            axis_sel[i] = bus.wen
                          && (addr_space(bus.waddr) == ADDR_MAIN)
                          && (addr_chan(bus.waddr) == chan_t'(i + 1))
                          && (addr_off(bus.waddr) == OFF_DAC_CTRL);
        end
    end

    // ------------------------------------------------
    // command registers, loaded at the write edge
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                cur_cmd[i] <= CUR_MID;   // zero amps
            end
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (axis_sel[i]) begin
                    cur_cmd[i] <= bus.wdata[CUR_W-1:0];   // upper bits dropped
                end
            end
        end
    end

    a_one_axis : assert property (@(posedge sysclk) disable iff (!rst_n)
        $onehot0(axis_sel))
        else $error("command write decoded to more than one axis");

endmodule

`default_nettype wire

/* hdl/board_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module board_regs (
    input  wire logic                 sysclk,
    input  wire logic                 rst_n,
    reg_bus_if.target                 bus,
    input  wire logic [3:0]           board_id,
    input  wire axis_pkg::axis_mask_t amp_disable,   // from safety checks
    output logic                      pwr_enable,
    output logic [3:0]                dout,
    output axis_pkg::axis_mask_t      clear_disable,
    output board_addr_pkg::reg_data_t status_rdata,
    output board_addr_pkg::reg_data_t digio_rdata
);
    import board_addr_pkg::*;
    import axis_pkg::*;

    logic chan0_wr;    // write to main space, chan 0
    logic status_wr;
    logic digio_wr;

    assign chan0_wr  = bus.wen && (addr_space(bus.waddr) == ADDR_MAIN)
                       && (addr_chan(bus.waddr) == '0);
    assign status_wr = chan0_wr && (addr_off(bus.waddr) == REG_STATUS);
    assign digio_wr  = chan0_wr && (addr_off(bus.waddr) == REG_DIGIO);

    // ------------------------------------------------
    // write side
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable    <= 1'b0;
            dout          <= 4'h0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;   // pulse lasts one cycle
            if (status_wr) begin
                pwr_enable <= bus.wdata[STAT_PWR_BIT];
                // pwr enable clears every axis, amp bits only their own
                clear_disable <= {NUM_AXES{bus.wdata[STAT_PWR_BIT]}}
                                 | bus.wdata[STAT_AMP_LSB +: NUM_AXES];
            end
            if (digio_wr) begin
                dout <= bus.wdata[3:0];
            end
        end
    end

    // status word, unused bits read 0
    always_comb begin
        status_rdata                           = '0;
        status_rdata[27:24]                    = board_id;
        status_rdata[STAT_PWR_BIT]             = pwr_enable;
        status_rdata[STAT_AMP_LSB +: NUM_AXES] = amp_disable;
        status_rdata[3:0]                      = dout;
    end

    assign digio_rdata = {28'd0, dout};   // dout in low nibble

    // back-to-back clears need back-to-back status writes
    a_clear_pulse : assert property (@(posedge sysclk) disable iff (!rst_n)
        (|clear_disable) && $past(|clear_disable)
            |-> $past(status_wr) && $past(status_wr, 2))
        else $error("clear_disable held without a second status write");

endmodule

`default_nettype wire

/* hdl/reg_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// internal register bus, no back-pressure
interface reg_bus_if;
    import board_addr_pkg::*;

    logic      wen;     // write strobe, register loads at this edge
    reg_addr_t waddr;
    reg_data_t wdata;
    reg_addr_t raddr;   // sampled every edge, data one cycle later

    // driven from the board ports
    modport host (
        output wen,
        output waddr,
        output wdata,
        output raddr
    );

    // register blocks
    modport target (
        input wen,
        input waddr,
        input wdata,
        input raddr
    );

endinterface

`default_nettype wire

/* hdl/axis_pkg.sv */
`default_nettype none

package axis_pkg;

    localparam int NUM_AXES   = 4;
    localparam int AXIS_IDX_W = $clog2(NUM_AXES);   // axis select width
    localparam int CUR_W      = 16;

    // currents are offset binary, CUR_MID is zero amps
    typedef logic [CUR_W-1:0] cur_t;
    typedef logic [NUM_AXES-1:0][CUR_W-1:0] cur_arr_t;   // [0] is axis 1

    typedef logic [NUM_AXES-1:0] axis_mask_t;   // one bit per axis

    localparam cur_t CUR_MID = 16'h8000;

    // ------------------------------------------------
    // over-current check
    // fb magnitude > 2 * cmd magnitude + margin trips
    localparam cur_t SAFETY_MARGIN = 16'h0200;
    localparam int   SAFETY_COUNT  = 8;    // consecutive cycles to trip
    localparam int   SAFETY_CNT_W  = $clog2(SAFETY_COUNT + 1);
    localparam int   CHK_W         = 18;   // room for 2 * 0x8000 + margin

endpackage

`default_nettype wire

/* hdl/board_addr_pkg.sv */
`default_nettype none

package board_addr_pkg;

    // register address layout {space, unused, chan, offset}
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int SPACE_W = 4;
    localparam int CHAN_W  = 4;
    localparam int OFF_W   = 4;

    typedef logic [ADDR_W-1:0]  reg_addr_t;
    typedef logic [DATA_W-1:0]  reg_data_t;
    typedef logic [SPACE_W-1:0] space_t;
    typedef logic [CHAN_W-1:0]  chan_t;
    typedef logic [OFF_W-1:0]   off_t;

    localparam space_t ADDR_MAIN = 4'h0;   // only space with registers
    localparam int     NUM_CHAN  = 5;      // chan 0 + four axes

    // ------------------------------------------------
    // channel 0 offsets
    localparam off_t REG_STATUS = 4'd0;
    localparam off_t REG_DIGIO  = 4'd10;

    // axis channel offsets
    localparam off_t OFF_ADC_DATA = 4'd0;  // measured current
    localparam off_t OFF_DAC_CTRL = 4'd1;  // current command

    // status write bits
    localparam int STAT_PWR_BIT = 19;      // board power enable
    localparam int STAT_AMP_LSB = 8;       // amp enables, one per axis

    // field extraction
    function automatic space_t addr_space(input reg_addr_t addr);
        return addr[ADDR_W-1 -: SPACE_W];
    endfunction

    function automatic chan_t addr_chan(input reg_addr_t addr);
        return addr[OFF_W +: CHAN_W];   // bits 7:4
    endfunction

    function automatic off_t addr_off(input reg_addr_t addr);
        return addr[OFF_W-1:0];
    endfunction

endpackage

`default_nettype wire
